// ==== sources.f ====
+incdir+.
id_pkg.sv
instr_decoder.sv
imm_gen.sv
reg_file.sv
id_pipe_ctrl.sv
id_ex_reg.sv
id_stage.sv
id_stage_sva.sv
id_stage_tb.sv

// ==== id_stage_tb.sv ====
`include "id_macros.svh"

module id_stage_tb
  import id_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int NUM_CYCLES   = 3000;
  localparam int FILL_TIMEOUT = 64;

  logic                      clk;
  logic                      reset_i;
  logic                      s_valid_i;
  logic [`ID_XLEN-1:0]       instr_i;
  logic [`ID_XLEN-1:0]       pc_i;
  logic                      stall_i;
  logic                      flush_i;
  logic                      bubble_i;
  wb_t                       wb_i;
  logic                      m_ready_i;
  logic                      m_valid_o;
  id_ex_t                    id_ex_o;
  logic [`ID_REG_ADDR_W-1:0] rs1_o;
  logic [`ID_REG_ADDR_W-1:0] rs2_o;
  logic                      rs1_used_o;
  logic                      rs2_used_o;

  // Reference model state
  logic [`ID_XLEN-1:0] model_regs [`ID_NUM_REGS];
  logic                exp_valid;
  id_ex_t              exp_entry;
  // Stage outputs seen before the edge, for the hold check
  logic                prev_valid;
  id_ex_t              prev_entry;
  logic                was_held;
  logic [6:0]          legal_ops [9];
  integer              seed;
  int                  fill_idx;
  int                  wait_count;
  int                  n_loads;
  int                  n_traps;
  int                  n_clears;

  id_stage DUT (.*);

  initial clk = 1'b0;
  always #4 clk = ~clk;

  // ====================
  // Decode model
  // ====================

  function automatic logic op_is(input logic [31:0] ins, input opcode_e op);
    return ins[6:0] == op;
  endfunction

  function automatic ctrl_t expect_ctrl(input logic [31:0] ins);
    ctrl_t c;
    logic  legal;
    legal = op_is(ins, OPC_OP) || op_is(ins, OPC_OP_IMM) || op_is(ins, OPC_LOAD) ||
            op_is(ins, OPC_STORE) || op_is(ins, OPC_BRANCH) || op_is(ins, OPC_JAL) ||
            op_is(ins, OPC_JALR) || op_is(ins, OPC_LUI) || op_is(ins, OPC_AUIPC);
    c = '0;
    c.reg_write = legal && !op_is(ins, OPC_STORE) && !op_is(ins, OPC_BRANCH);
    c.mem_read  = op_is(ins, OPC_LOAD);
    c.mem_write = op_is(ins, OPC_STORE);
    c.is_branch = op_is(ins, OPC_BRANCH);
    c.is_jal    = op_is(ins, OPC_JAL);
    c.is_jalr   = op_is(ins, OPC_JALR);
    c.trap      = !legal;
    if (op_is(ins, OPC_AUIPC) || op_is(ins, OPC_JAL)) c.a_src = A_SRC_PC;
    else if (op_is(ins, OPC_LUI)) c.a_src = A_SRC_ZERO;
    else c.a_src = A_SRC_RS1;
    c.b_imm = !(op_is(ins, OPC_OP) || op_is(ins, OPC_BRANCH));
    if (op_is(ins, OPC_OP) || op_is(ins, OPC_OP_IMM)) c.alu_op = ALU_FUNCT;
    else if (op_is(ins, OPC_BRANCH)) c.alu_op = ALU_BRANCH;
    else c.alu_op = ALU_ADD;
    if (op_is(ins, OPC_LOAD)) c.res_src = RES_MEM;
    else if (op_is(ins, OPC_JAL) || op_is(ins, OPC_JALR)) c.res_src = RES_PC4;
    else c.res_src = RES_ALU;
    return c;
  endfunction

  function automatic logic [31:0] expect_imm(input logic [31:0] ins);
    if (op_is(ins, OPC_STORE))
      return {{20{ins[31]}}, ins[31:25], ins[11:7]};
    if (op_is(ins, OPC_BRANCH))
      return {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
    if (op_is(ins, OPC_LUI) || op_is(ins, OPC_AUIPC))
      return {ins[31:12], 12'h000};
    if (op_is(ins, OPC_JAL))
      return {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
    return {{20{ins[31]}}, ins[31:20]};
  endfunction

  function automatic logic expect_rs1_used(input logic [31:0] ins);
    return !(op_is(ins, OPC_LUI) || op_is(ins, OPC_AUIPC) || op_is(ins, OPC_JAL));
  endfunction

  function automatic logic expect_rs2_used(input logic [31:0] ins);
    return op_is(ins, OPC_OP) || op_is(ins, OPC_STORE) || op_is(ins, OPC_BRANCH);
  endfunction

  // Same-cycle write-back wins over the stored value
  function automatic logic [31:0] model_read(input logic [4:0] addr);
    if (addr == 5'd0) return '0;
    if (wb_i.we && (wb_i.rd == addr)) return wb_i.data;
    return model_regs[addr];
  endfunction

  function automatic id_ex_t cleared_entry();
    id_ex_t e;
    e       = '0;
    e.instr = `ID_NOP_INSTR;
    return e;
  endfunction

  function automatic id_ex_t expect_entry();
    id_ex_t e;
    e.ctrl     = expect_ctrl(instr_i);
    e.rd       = instr_i[11:7];
    e.rs1      = instr_i[19:15];
    e.rs2      = instr_i[24:20];
    e.funct3   = instr_i[14:12];
    e.funct7   = instr_i[31:25];
    e.rs1_data = model_read(instr_i[19:15]);
    e.rs2_data = model_read(instr_i[24:20]);
    e.imm      = expect_imm(instr_i);
    e.pc       = pc_i;
    e.instr    = instr_i;
    return e;
  endfunction

  // ====================
  // Stimulus and checks
  // ====================

  task automatic stop_on_error(input string line);
    $display("%s", line);
    $display("Something failed");
    $fatal(1);
  endtask

  // Mostly supported opcodes, some random ones for the trap
  function automatic logic [31:0] random_instr();
    logic [31:0] word;
    int          pick;
    word = $random(seed);
    pick = {$random(seed)} % 12;
    if (pick < 9) word[6:0] = legal_ops[pick];
    return word;
  endfunction

  task automatic drive_random();
    logic [31:0] r;
    // Fetch keeps its item while stalled or bubbled
    if (!(stall_i || bubble_i)) begin
      s_valid_i = ({$random(seed)} % 4) != 0;
      instr_i   = random_instr();
      pc_i      = {$random(seed)} & 32'hFFFF_FFFC;
    end
    stall_i   = {$random(seed)} % 10 == 0;
    flush_i   = {$random(seed)} % 20 == 0;
    bubble_i  = {$random(seed)} % 10 == 0;
    m_ready_i = {$random(seed)} % 10 < 7;
    r         = $random(seed);
    wb_i.we   = r[0];
    // Aim at rs1 now and then to hit the bypass
    wb_i.rd   = r[3:1] == 3'd0 ? instr_i[19:15] : r[8:4];
    wb_i.data = $random(seed);
  endtask

  // Next state for the coming rising edge, same priority as the stage
  task automatic step_model();
    prev_valid = m_valid_o;
    prev_entry = id_ex_o;
    was_held   = 1'b0;
    if (reset_i || flush_i || (!stall_i && !(exp_valid && !m_ready_i) && bubble_i)) begin
      exp_valid = 1'b0;
      exp_entry = cleared_entry();
      n_clears++;
    end else if (stall_i || (exp_valid && !m_ready_i)) begin
      was_held = 1'b1;
    end else begin
      exp_valid = s_valid_i;
      exp_entry = expect_entry();
      n_loads++;
      if (s_valid_i && exp_entry.ctrl.trap) n_traps++;
    end
    if (wb_i.we && (wb_i.rd != 5'd0)) model_regs[wb_i.rd] = wb_i.data;
  endtask

  task automatic check_registered();
    if (was_held) begin
      assert ((id_ex_o === prev_entry) && (m_valid_o === prev_valid))
        else stop_on_error($sformatf("** Error at %0t ns: held entry changed to %h",
                                     $time, id_ex_o));
    end
    assert (m_valid_o === exp_valid)
      else stop_on_error($sformatf("** Error at %0t ns: m_valid_o is %b, expected %b",
                                   $time, m_valid_o, exp_valid));
    assert (id_ex_o === exp_entry)
      else stop_on_error($sformatf("** Error at %0t ns: id_ex_o is %h, expected %h",
                                   $time, id_ex_o, exp_entry));
  endtask

  task automatic check_hazard();
    assert ((rs1_o === instr_i[19:15]) && (rs2_o === instr_i[24:20]) &&
            (rs1_used_o === expect_rs1_used(instr_i)) &&
            (rs2_used_o === expect_rs2_used(instr_i)))
      else stop_on_error($sformatf("** Error at %0t ns: hazard outputs %0d/%0d %b/%b for %h",
                                   $time, rs1_o, rs2_o, rs1_used_o, rs2_used_o, instr_i));
  endtask

  initial begin
    seed      = 53;
    legal_ops = '{OPC_LOAD, OPC_OP_IMM, OPC_AUIPC, OPC_STORE, OPC_OP,
                  OPC_LUI, OPC_BRANCH, OPC_JALR, OPC_JAL};
    reset_i   = 1'b1;
    s_valid_i = 1'b0;
    instr_i   = `ID_NOP_INSTR;
    pc_i      = '0;
    stall_i   = 1'b0;
    flush_i   = 1'b0;
    bubble_i  = 1'b0;
    wb_i      = '0;
    m_ready_i = 1'b1;
    exp_valid = 1'b0;
    exp_entry = cleared_entry();
    n_loads   = 0;
    n_traps   = 0;
    n_clears  = 0;
    model_regs[0] = '0;

    repeat (8) begin
      step_model();
      @(negedge clk);
      check_registered();
    end
    reset_i = 1'b0;

    // Give every register a known value before random traffic
    fill_idx   = 1;
    wait_count = 0;
    while (fill_idx < `ID_NUM_REGS) begin
      if (wait_count == FILL_TIMEOUT) stop_on_error("Timeout: register file fill did not finish");
      wb_i.we   = 1'b1;
      wb_i.rd   = fill_idx[4:0];
      wb_i.data = $random(seed);
      step_model();
      @(negedge clk);
      check_registered();
      fill_idx++;
      wait_count++;
    end

    for (int i = 0; i < NUM_CYCLES; i++) begin
      drive_random();
      #1;
      check_hazard();
      step_model();
      @(negedge clk);
      check_registered();
    end

    $display("Loads %0d, traps %0d, clears %0d", n_loads, n_traps, n_clears);
    $display("Everything OK");
    $finish;
  end

endmodule

// ==== id_stage_sva.sv ====
module id_stage_sva
  import id_pkg::*;
(
  input logic   clk,
  input logic   reset_i,
  input logic   flush_i,
  input logic   m_ready_i,
  input logic   m_valid_o,
  input id_ex_t id_ex_o
);

  timeunit 1ns;
  timeprecision 1ps;

  // ====================
  // Reset and handshake
  // ====================

  property valid_low_after_reset;
    @(posedge clk) reset_i |=> !m_valid_o;
  endproperty

  // A waiting entry stays put until EX takes it or a flush drops it
  property stable_under_backpressure;
    @(posedge clk) disable iff (reset_i)
      (m_valid_o && !m_ready_i && !flush_i) |=> (m_valid_o && $stable(id_ex_o));
  endproperty

  // x0 operand of an accepted entry
  property x0_reads_zero;
    @(posedge clk) disable iff (reset_i)
      (m_valid_o && m_ready_i && (id_ex_o.rs1 == '0)) |-> (id_ex_o.rs1_data == '0);
  endproperty

  reset_check: assert property (valid_low_after_reset)
    else $error("m_valid_o is high in the cycle after reset");
  stable_check: assert property (stable_under_backpressure)
    else $error("ID/EX entry changed while EX was not ready");
  x0_check: assert property (x0_reads_zero)
    else $error("rs1_data is not zero for rs1 = x0");

endmodule

bind id_stage id_stage_sva u_sva (.*);

// ==== id_stage.sv ====
`include "id_macros.svh"

module id_stage
  import id_pkg::*;
(
  input  logic                      clk,
  input  logic                      reset_i,
  input  logic                      s_valid_i,
  input  logic [`ID_XLEN-1:0]       instr_i,
  input  logic [`ID_XLEN-1:0]       pc_i,
  input  logic                      stall_i,
  input  logic                      flush_i,
  input  logic                      bubble_i,
  input  wb_t                       wb_i,
  input  logic                      m_ready_i,
  output logic                      m_valid_o,
  output id_ex_t                    id_ex_o,
  output logic [`ID_REG_ADDR_W-1:0] rs1_o,
  output logic [`ID_REG_ADDR_W-1:0] rs2_o,
  output logic                      rs1_used_o,
  output logic                      rs2_used_o
);

  ctrl_t                     dec_ctrl;
  logic [`ID_REG_ADDR_W-1:0] dec_rd;
  logic [2:0]                dec_funct3;
  logic [6:0]                dec_funct7;
  imm_type_e                 dec_imm_type;
  logic [`ID_XLEN-1:0]       imm;
  logic [`ID_XLEN-1:0]       rs1_data;
  logic [`ID_XLEN-1:0]       rs2_data;
  logic                      load;
  logic                      clear;
  id_ex_t                    id_ex_d;

  // ====================
  // Decode datapath
  // ====================

  instr_decoder u_decoder (
    .instr_i    (instr_i),
    .ctrl_o     (dec_ctrl),
    .rd_o       (dec_rd),
    .rs1_o      (rs1_o),
    .rs2_o      (rs2_o),
    .funct3_o   (dec_funct3),
    .funct7_o   (dec_funct7),
    .imm_type_o (dec_imm_type),
    .rs1_used_o (rs1_used_o),
    .rs2_used_o (rs2_used_o)
  );

  imm_gen u_imm_gen (
    .instr_i    (instr_i),
    .imm_type_i (dec_imm_type),
    .imm_o      (imm)
  );

  // Operands come back in the same cycle as the decode
  reg_file u_reg_file (
    .clk        (clk),
    .rs1_i      (rs1_o),
    .rs2_i      (rs2_o),
    .wb_i       (wb_i),
    .rs1_data_o (rs1_data),
    .rs2_data_o (rs2_data)
  );

  assign id_ex_d = '{
    ctrl:     dec_ctrl,
    rd:       dec_rd,
    rs1:      rs1_o,
    rs2:      rs2_o,
    funct3:   dec_funct3,
    funct7:   dec_funct7,
    rs1_data: rs1_data,
    rs2_data: rs2_data,
    imm:      imm,
    pc:       pc_i,
    instr:    instr_i
  };

  // ====================
  // ID/EX register
  // ====================

  id_pipe_ctrl u_pipe_ctrl (
    .clk       (clk),
    .reset_i   (reset_i),
    .s_valid_i (s_valid_i),
    .stall_i   (stall_i),
    .flush_i   (flush_i),
    .bubble_i  (bubble_i),
    .m_ready_i (m_ready_i),
    .m_valid_o (m_valid_o),
    .load_o    (load),
    .clear_o   (clear)
  );

  id_ex_reg u_id_ex_reg (
    .clk     (clk),
    .load_i  (load),
    .clear_i (clear),
    .d_i     (id_ex_d),
    .q_o     (id_ex_o)
  );

endmodule

// ==== id_ex_reg.sv ====
`include "id_macros.svh"

module id_ex_reg
  import id_pkg::*;
(
  input  logic   clk,
  input  logic   load_i,
  input  logic   clear_i,
  input  id_ex_t d_i,
  output id_ex_t q_o
);

  id_ex_t nop_entry;

  // Cleared entry: no control, zero fields, NOP encoding
  always_comb begin
    nop_entry       = '0;
    nop_entry.instr = `ID_NOP_INSTR;
  end

  always_ff @(posedge clk) begin
    if (clear_i) begin
      q_o <= nop_entry;
    end else if (load_i) begin
      q_o <= d_i;
    end
  end

endmodule

// ==== id_pipe_ctrl.sv ====
module id_pipe_ctrl (
  input  logic clk,
  input  logic reset_i,
  input  logic s_valid_i,
  input  logic stall_i,
  input  logic flush_i,
  input  logic bubble_i,
  input  logic m_ready_i,
  output logic m_valid_o,
  output logic load_o,
  output logic clear_o
);

  logic hold;

  // ====================
  // Register actions
  // ====================

  // Stall or back-pressure freezes the entry
  assign hold = stall_i || (m_valid_o && !m_ready_i);

  // Flush beats hold, hold beats bubble
  assign clear_o = reset_i || flush_i || (!hold && bubble_i);

  // Decoded item is taken whenever nothing stronger applies
  assign load_o = !clear_o && !hold;

  // ====================
  // Valid bit
  // ====================

  always_ff @(posedge clk) begin
    if (clear_o) begin
      m_valid_o <= 1'b0;
    end else if (load_o) begin
      m_valid_o <= s_valid_i;
    end
  end

endmodule

// ==== reg_file.sv ====
`include "id_macros.svh"

module reg_file
  import id_pkg::*;
(
  input  logic                      clk,
  input  logic [`ID_REG_ADDR_W-1:0] rs1_i,
  input  logic [`ID_REG_ADDR_W-1:0] rs2_i,
  input  wb_t                       wb_i,
  output logic [`ID_XLEN-1:0]       rs1_data_o,
  output logic [`ID_XLEN-1:0]       rs2_data_o
);

  logic [`ID_XLEN-1:0] regs [`ID_NUM_REGS];

  // x0 is never written
  always_ff @(posedge clk) begin
    if (wb_i.we && (wb_i.rd != '0)) begin
      regs[wb_i.rd] <= wb_i.data;
    end
  end

  // Read with x0 forced to zero and write-back bypass
  function automatic logic [`ID_XLEN-1:0] read_port(
    input logic [`ID_REG_ADDR_W-1:0] addr
  );
    if (addr == '0) begin
      return '0;
    end else if (wb_i.we && (wb_i.rd == addr)) begin
      return wb_i.data;
    end
    return regs[addr];
  endfunction

  always_comb begin
    rs1_data_o = read_port(rs1_i);
    rs2_data_o = read_port(rs2_i);
  end

endmodule

// ==== imm_gen.sv ====
`include "id_macros.svh"

module imm_gen
  import id_pkg::*;
(
  input  logic [`ID_XLEN-1:0] instr_i,
  input  imm_type_e           imm_type_i,
  output logic [`ID_XLEN-1:0] imm_o
);

  logic [`ID_XLEN-1:0] imm_i;
  logic [`ID_XLEN-1:0] imm_s;
  logic [`ID_XLEN-1:0] imm_b;
  logic [`ID_XLEN-1:0] imm_u;
  logic [`ID_XLEN-1:0] imm_j;

  // All formats sign-extend from bit 31
  assign imm_i = {{(`ID_XLEN-12){instr_i[31]}}, instr_i[31:20]};
  assign imm_s = {{(`ID_XLEN-12){instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
  assign imm_b = {{(`ID_XLEN-12){instr_i[31]}}, instr_i[7], instr_i[30:25],
                  instr_i[11:8], 1'b0};
  assign imm_u = {instr_i[31:12], 12'b0};
  assign imm_j = {{(`ID_XLEN-20){instr_i[31]}}, instr_i[19:12], instr_i[20],
                  instr_i[30:21], 1'b0};

  always_comb begin
    case (imm_type_i)
      IMM_S:   imm_o = imm_s;
      IMM_B:   imm_o = imm_b;
      IMM_U:   imm_o = imm_u;
      IMM_J:   imm_o = imm_j;
      default: imm_o = imm_i;
    endcase
  end

endmodule

// ==== instr_decoder.sv ====
`include "id_macros.svh"

module instr_decoder
  import id_pkg::*;
(
  input  logic [`ID_XLEN-1:0]       instr_i,
  output ctrl_t                     ctrl_o,
  output logic [`ID_REG_ADDR_W-1:0] rd_o,
  output logic [`ID_REG_ADDR_W-1:0] rs1_o,
  output logic [`ID_REG_ADDR_W-1:0] rs2_o,
  output logic [2:0]                funct3_o,
  output logic [6:0]                funct7_o,
  output imm_type_e                 imm_type_o,
  output logic                      rs1_used_o,
  output logic                      rs2_used_o
);

  logic [6:0] opcode;

  // ====================
  // Instruction fields
  // ====================

  assign opcode   = instr_i[6:0];
  assign rd_o     = instr_i[11:7];
  assign funct3_o = instr_i[14:12];
  assign rs1_o    = instr_i[19:15];
  assign rs2_o    = instr_i[24:20];
  assign funct7_o = instr_i[31:25];

  // ====================
  // Control decode
  // ====================

  always_comb begin
    // Defaults describe the common register-immediate shape
    ctrl_o         = '0;
    ctrl_o.a_src   = A_SRC_RS1;
    ctrl_o.b_imm   = 1'b1;
    ctrl_o.alu_op  = ALU_ADD;
    ctrl_o.res_src = RES_ALU;
    imm_type_o     = IMM_I;
    rs1_used_o     = 1'b1;
    rs2_used_o     = 1'b0;

    // Opcodes with low bits other than 11 fall into the default arm
    case (opcode)
      OPC_OP: begin
        ctrl_o.reg_write = 1'b1;
        ctrl_o.b_imm     = 1'b0;
        ctrl_o.alu_op    = ALU_FUNCT;
        rs2_used_o       = 1'b1;
      end
      OPC_OP_IMM: begin
        ctrl_o.reg_write = 1'b1;
        ctrl_o.alu_op    = ALU_FUNCT;
      end
      OPC_LOAD: begin
        ctrl_o.reg_write = 1'b1;
        ctrl_o.mem_read  = 1'b1;
        ctrl_o.res_src   = RES_MEM;
      end
      OPC_STORE: begin
        ctrl_o.mem_write = 1'b1;
        imm_type_o       = IMM_S;
        rs2_used_o       = 1'b1;
      end
      OPC_BRANCH: begin
        ctrl_o.is_branch = 1'b1;
        ctrl_o.b_imm     = 1'b0;
        ctrl_o.alu_op    = ALU_BRANCH;
        imm_type_o       = IMM_B;
        rs2_used_o       = 1'b1;
      end
      OPC_JAL: begin
        ctrl_o.reg_write = 1'b1;
        ctrl_o.is_jal    = 1'b1;
        ctrl_o.a_src     = A_SRC_PC;
        ctrl_o.res_src   = RES_PC4;
        imm_type_o       = IMM_J;
        rs1_used_o       = 1'b0;
      end
      OPC_JALR: begin
        ctrl_o.reg_write = 1'b1;
        ctrl_o.is_jalr   = 1'b1;
        ctrl_o.res_src   = RES_PC4;
      end
      OPC_LUI: begin
        ctrl_o.reg_write = 1'b1;
        ctrl_o.a_src     = A_SRC_ZERO;
        imm_type_o       = IMM_U;
        rs1_used_o       = 1'b0;
      end
      OPC_AUIPC: begin
        ctrl_o.reg_write = 1'b1;
        ctrl_o.a_src     = A_SRC_PC;
        imm_type_o       = IMM_U;
        rs1_used_o       = 1'b0;
      end
      default: begin
        // Illegal instruction: no side effects, only the trap flag
        ctrl_o.trap = 1'b1;
      end
    endcase
  end

endmodule

// ==== id_pkg.sv ====
`include "id_macros.svh"

package id_pkg;

  // ====================
  // Encodings
  // ====================

  // Base integer major opcodes, low bits included
  typedef enum logic [6:0] {
    OPC_LOAD   = 7'b0000011,
    OPC_OP_IMM = 7'b0010011,
    OPC_AUIPC  = 7'b0010111,
    OPC_STORE  = 7'b0100011,
    OPC_OP     = 7'b0110011,
    OPC_LUI    = 7'b0110111,
    OPC_BRANCH = 7'b1100011,
    OPC_JALR   = 7'b1100111,
    OPC_JAL    = 7'b1101111
  } opcode_e;

  typedef enum logic [2:0] {
    IMM_I = 3'd0,
    IMM_S = 3'd1,
    IMM_B = 3'd2,
    IMM_U = 3'd3,
    IMM_J = 3'd4
  } imm_type_e;

  // FUNCT leaves the operation to EX, which reads funct3/funct7
  typedef enum logic [1:0] {
    ALU_ADD    = 2'd0,
    ALU_BRANCH = 2'd1,
    ALU_FUNCT  = 2'd2
  } alu_op_e;

  typedef enum logic [1:0] {
    A_SRC_RS1  = 2'd0,
    A_SRC_PC   = 2'd1,
    A_SRC_ZERO = 2'd2
  } a_src_e;

  typedef enum logic [1:0] {
    RES_ALU = 2'd0,
    RES_MEM = 2'd1,
    RES_PC4 = 2'd2
  } res_src_e;

  // ====================
  // Bundles
  // ====================

  typedef struct packed {
    logic     reg_write;
    logic     mem_read;
    logic     mem_write;
    logic     is_branch;
    logic     is_jal;
    logic     is_jalr;
    logic     trap;
    a_src_e   a_src;
    logic     b_imm;
    alu_op_e  alu_op;
    res_src_e res_src;
  } ctrl_t;

  // Write port from write-back
  typedef struct packed {
    logic                      we;
    logic [`ID_REG_ADDR_W-1:0] rd;
    logic [`ID_XLEN-1:0]       data;
  } wb_t;

  typedef struct packed {
    ctrl_t                     ctrl;
    logic [`ID_REG_ADDR_W-1:0] rd;
    logic [`ID_REG_ADDR_W-1:0] rs1;
    logic [`ID_REG_ADDR_W-1:0] rs2;
    logic [2:0]                funct3;
    logic [6:0]                funct7;
    logic [`ID_XLEN-1:0]       rs1_data;
    logic [`ID_XLEN-1:0]       rs2_data;
    logic [`ID_XLEN-1:0]       imm;
    logic [`ID_XLEN-1:0]       pc;
    logic [`ID_XLEN-1:0]       instr;
  } id_ex_t;

endpackage

// ==== id_macros.svh ====
`ifndef ID_MACROS_SVH
`define ID_MACROS_SVH

// ====================
// Datapath sizes
// ====================

// Data and PC width
`define ID_XLEN 32

// Register number width and register count
`define ID_REG_ADDR_W 5
`define ID_NUM_REGS 32

// addi x0, x0, 0
`define ID_NOP_INSTR 32'h0000_0013

`endif
